//--- hdl/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// ************************************************************************
// fetch unit configuration
// ************************************************************************

// boot address
// the pc takes this value on reset
`define IFU_RESET_PC 32'h8000_0000

// number of cache lines, power of two
`define IC_SETS 16

// 32-bit words per line, power of two
// also the number of beats in one refill burst
`define IC_LINE_WORDS 4

`endif

//--- hdl/ifu_pkg.sv
`default_nettype none

// pipeline-side types of the fetch unit
package ifu_pkg;

	// ************************************************************************
	// decode interface
	// ************************************************************************

	// one instruction handed to decode
	typedef struct packed {
		logic [31:0] pc;
		// raw instruction word from the cache
		logic [31:0] inst;
		// set for jal and backward branches
		logic        pred_taken;
	} fetch_out_t;

	// ************************************************************************
	// control strobes from later stages
	// ************************************************************************

	// mispredict or trap target, single cycle
	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// drop one cache line after memory was rewritten
	typedef struct packed {
		logic        valid;
		// any byte address inside the line
		logic [31:0] addr;
	} inval_t;

endpackage

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

// memory bus types, read channels only
package mem_pkg;

	// ************************************************************************
	// read address channel
	// ************************************************************************

	// one burst request
	typedef struct packed {
		// line aligned
		logic [31:0] addr;
		// beats minus one
		logic [7:0]  len;
	} mem_ar_t;

	// ************************************************************************
	// read data channel
	// ************************************************************************

	// one data beat of a burst
	typedef struct packed {
		logic [31:0] data;
		// final beat of the burst
		logic        last;
	} mem_r_t;

endpackage

`default_nettype wire

//--- hdl/icache_tags.sv
`default_nettype none
`timescale 1ns/100ps

`include "ifu_cfg.svh"

// tag store of the direct-mapped instruction cache
module icache_tags (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic [31:0]     lookup_addr,
	input  wire logic            line_done,
	input  wire ifu_pkg::inval_t inval,
	output logic                 hit
);

	// byte offset inside a line, then set index, then tag
	localparam int OFF_W = $clog2(`IC_LINE_WORDS) + 2;
	localparam int IDX_W = $clog2(`IC_SETS);
	localparam int TAG_W = 32 - OFF_W - IDX_W;

	logic [TAG_W-1:0] tags [`IC_SETS];
	logic [`IC_SETS-1:0] valid;

	// lookup side fields
	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	// invalidate side fields
	logic [IDX_W-1:0] iv_idx;
	logic [TAG_W-1:0] iv_tag;
	logic             iv_match;

	assign lk_idx = lookup_addr[OFF_W +: IDX_W];
	assign lk_tag = lookup_addr[31 -: TAG_W];
	assign iv_idx = inval.addr[OFF_W +: IDX_W];
	assign iv_tag = inval.addr[31 -: TAG_W];

	// combinational hit compare
	assign hit = valid[lk_idx] && (tags[lk_idx] == lk_tag);

	// a fill landing in the same set this cycle is what the invalidate sees
	assign iv_match = (line_done && iv_idx == lk_idx) ? (iv_tag == lk_tag)
		: (tags[iv_idx] == iv_tag);

	// tag write on the last refill beat
	always_ff @(posedge clk) begin
		if (line_done) begin
			tags[lk_idx] <= lk_tag;
		end
	end

	// valid bits, invalidate applied after the fill
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else begin
			if (line_done) begin
				valid[lk_idx] <= 1'b1;
			end
			if (inval.valid && iv_match) begin
				valid[iv_idx] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/icache_data.sv
`default_nettype none
`timescale 1ns/100ps

`include "ifu_cfg.svh"

// data store of the direct-mapped instruction cache
module icache_data (
	input  wire logic           clk,
	input  wire logic [31:0]    lookup_addr,
	input  wire logic           word_we,
	input  wire logic [31:0]    fill_index,
	input  wire mem_pkg::mem_r_t beat,
	output logic [31:0]         word
);

	// word offset inside a line, then set index
	localparam int WRD_W = $clog2(`IC_LINE_WORDS);
	localparam int IDX_W = $clog2(`IC_SETS);
	localparam int OFF_W = WRD_W + 2;

	// ************************************************************************
	// line array
	// ************************************************************************

	logic [31:0] lines [`IC_SETS][`IC_LINE_WORDS];

	// read port fields
	logic [IDX_W-1:0] rd_set;
	logic [WRD_W-1:0] rd_wrd;
	// fill port fields
	logic [IDX_W-1:0] wr_set;
	logic [WRD_W-1:0] wr_wrd;

	assign rd_set = lookup_addr[OFF_W +: IDX_W];
	assign rd_wrd = lookup_addr[2 +: WRD_W];
	assign wr_set = fill_index[OFF_W +: IDX_W];
	assign wr_wrd = fill_index[2 +: WRD_W];

	// one refill beat per write
	always_ff @(posedge clk) begin
		if (word_we) begin
			lines[wr_set][wr_wrd] <= beat.data;
		end
	end

	// ************************************************************************
	// word select
	// ************************************************************************

	// combinational read, valid only together with a tag hit
	assign word = lines[rd_set][rd_wrd];

endmodule

`default_nettype wire

//--- hdl/fetch_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "ifu_cfg.svh"

// fetch controller
// pc, static prediction and refill bursts
module fetch_ctrl (
	input  wire logic               clk,
	input  wire logic               rst,

	// cache results
	input  wire logic               hit,
	input  wire logic [31:0]        word,

	// cache control
	output logic [31:0]             lookup_addr,
	output logic                    word_we,
	output logic [31:0]             fill_index,
	output logic                    line_done,

	// decode side
	output logic                    fetch_valid,
	input  wire logic               fetch_ready,
	output ifu_pkg::fetch_out_t     fetch,
	input  wire ifu_pkg::redirect_t redirect,

	// memory read address channel
	output logic                    ar_valid,
	input  wire logic               ar_ready,
	output mem_pkg::mem_ar_t        ar,

	// memory read data channel
	input  wire logic               r_valid,
	output logic                    r_ready,
	input  wire mem_pkg::mem_r_t    r
);

	localparam int CNT_W = $clog2(`IC_LINE_WORDS);
	// byte offset inside a line
	localparam int OFF_W = CNT_W + 2;

	typedef enum logic [1:0] {
		S_LOOKUP,
		S_REQUEST,
		S_RECEIVE
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [31:0] pc;
	logic [31:0] pc_nxt;
	// line being refilled
	logic [31:0] line_addr;
	logic [CNT_W-1:0] beat_cnt;

	logic is_jal;
	logic is_branch;
	logic take;
	logic [31:0] imm_j;
	logic [31:0] imm_b;
	logic [31:0] target;
	logic [31:0] seq_pc;

	logic xfer;
	logic miss;
	logic ar_go;

	// ************************************************************************
	// predecode and static prediction
	// ************************************************************************

	assign is_jal = (word[6:0] == 7'b1101111);
	assign is_branch = (word[6:0] == 7'b1100011);

	// sign-extended J and B immediates
	assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
	assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

	// jal always taken and a branch only when its offset sign bit is set
	assign take = is_jal || (is_branch && word[31]);
	assign target = pc + (is_jal ? imm_j : imm_b);
	assign seq_pc = pc + 32'd4;

	// ************************************************************************
	// handshakes
	// ************************************************************************

	// lookup hit is offered unless a redirect kills it
	assign fetch_valid = (state == S_LOOKUP) && hit && !redirect.valid;
	assign xfer = fetch_valid && fetch_ready;
	assign miss = (state == S_LOOKUP) && !hit && !redirect.valid;

	assign fetch = '{pc: pc, inst: word, pred_taken: take};

	// burst request for the whole line
	assign ar_valid = (state == S_REQUEST);
	assign ar = '{addr: line_addr, len: 8'(`IC_LINE_WORDS - 1)};
	assign ar_go = ar_valid && ar_ready;

	// data ready held high for the whole refill
	assign r_ready = (state == S_RECEIVE);
	assign word_we = r_valid && r_ready;
	assign line_done = word_we && r.last;
	assign fill_index = {line_addr[31:OFF_W], beat_cnt, 2'b00};

	// stores see the pc or the refill line while filling
	assign lookup_addr = (state == S_LOOKUP) ? pc : line_addr;

	// ************************************************************************
	// next pc and next state
	// ************************************************************************

	always_comb begin
		// redirect beats both the prediction and a transfer
		if (redirect.valid) begin
			pc_nxt = redirect.target;
		end else if (xfer) begin
			pc_nxt = take ? target : seq_pc;
		end else begin
			pc_nxt = pc;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_LOOKUP: begin
				if (miss) begin
					state_nxt = S_REQUEST;
				end
			end
			S_REQUEST: begin
				if (ar_go) begin
					state_nxt = S_RECEIVE;
				end
			end
			S_RECEIVE: begin
				// burst always runs to its last beat
				if (line_done) begin
					state_nxt = S_LOOKUP;
				end
			end
			default: begin
				state_nxt = S_LOOKUP;
			end
		endcase
	end

	// ************************************************************************
	// registers
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_LOOKUP;
			pc <= `IFU_RESET_PC;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			pc <= pc_nxt;
			// beat count restarts with each burst
			if (ar_go) begin
				beat_cnt <= '0;
			end else if (word_we) begin
				beat_cnt <= beat_cnt + CNT_W'(1);
			end
		end
	end

	// latch the missing line
	always_ff @(posedge clk) begin
		if (miss) begin
			line_addr <= {pc[31:OFF_W], {OFF_W{1'b0}}};
		end
	end

endmodule

`default_nettype wire

//--- hdl/ifu_top.sv
`default_nettype none
`timescale 1ns/100ps

// instruction fetch unit
// tag store and data store side by side, joined by the controller
module ifu_top (
	input  wire logic               clk,
	input  wire logic               rst,

	// decode side
	output logic                    fetch_valid,
	input  wire logic               fetch_ready,
	output ifu_pkg::fetch_out_t     fetch,

	// strobes from later stages
	input  wire ifu_pkg::redirect_t redirect,
	input  wire ifu_pkg::inval_t    inval,

	// memory read bus
	output logic                    ar_valid,
	input  wire logic               ar_ready,
	output mem_pkg::mem_ar_t        ar,
	input  wire logic               r_valid,
	output logic                    r_ready,
	input  wire mem_pkg::mem_r_t    r
);

	// lookup and fill wires between the blocks
	logic [31:0] lookup_addr;
	logic        hit;
	logic [31:0] word;
	logic        word_we;
	logic [31:0] fill_index;
	logic        line_done;

	// valid bits and tags
	icache_tags u_tags (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (lookup_addr),
		.line_done   (line_done),
		.inval       (inval),
		.hit         (hit)
	);

	// line data, refilled straight from the bus beat
	icache_data u_data (
		.clk         (clk),
		.lookup_addr (lookup_addr),
		.word_we     (word_we),
		.fill_index  (fill_index),
		.beat        (r),
		.word        (word)
	);

	// pc, prediction and refill
	fetch_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.hit         (hit),
		.word        (word),
		.lookup_addr (lookup_addr),
		.word_we     (word_we),
		.fill_index  (fill_index),
		.line_done   (line_done),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.fetch       (fetch),
		.redirect    (redirect),
		.ar_valid    (ar_valid),
		.ar_ready    (ar_ready),
		.ar          (ar),
		.r_valid     (r_valid),
		.r_ready     (r_ready),
		.r           (r)
	);

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`default_nettype none
`timescale 1ns/100ps

// behavioral read memory, 1 KiB aliased
// stalls come from ar_ok and r_ok, driven by the testbench
module tb_mem_model (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             ar_ok,
	input  wire logic             r_ok,
	input  wire logic             ar_valid,
	output logic                  ar_ready,
	input  wire mem_pkg::mem_ar_t ar,
	output logic                  r_valid,
	input  wire logic             r_ready,
	output mem_pkg::mem_r_t       r
);

	// image, written by the testbench through the hierarchy
	logic [31:0] mem [256];

	logic       busy;
	logic [7:0] base;
	logic [7:0] cnt;
	logic [7:0] len;

	// one burst at a time
	assign ar_ready = !busy && ar_ok;
	assign r_valid = busy && r_ok;
	// word index wraps at 1 KiB
	assign r.data = mem[base + cnt];
	assign r.last = (cnt == len);

	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (ar_valid && ar_ready) begin
			busy <= 1'b1;
			base <= ar.addr[9:2];
			len <= ar.len;
			cnt <= '0;
		end else if (r_valid && r_ready) begin
			cnt <= r.last ? 8'd0 : cnt + 8'd1;
			if (r.last) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_ifu.sv
`default_nettype none
`timescale 1ns/100ps

`include "ifu_cfg.svh"

module tb_ifu;

	localparam int N_FETCH = 3000;
	// cycle bound per fetch, well above a refill with stalls
	localparam int CYC_PER_FETCH = 60;
	localparam int OFF_W = $clog2(`IC_LINE_WORDS) + 2;
	localparam int IDX_W = $clog2(`IC_SETS);
	localparam int TAG_W = 32 - OFF_W - IDX_W;

	logic clk = 1'b0;
	logic rst;
	logic fetch_valid, fetch_ready, ar_valid, ar_ready, r_valid, r_ready;
	logic ar_ok, r_ok;
	ifu_pkg::fetch_out_t fetch;
	ifu_pkg::redirect_t redirect;
	ifu_pkg::inval_t inval;
	mem_pkg::mem_ar_t ar;
	mem_pkg::mem_r_t r;

	// reference model state
	logic [31:0] model_mem [256];
	logic [`IC_SETS-1:0] resident;
	logic [TAG_W-1:0] res_tag [`IC_SETS];
	logic [31:0] exp_pc, fill_addr, rw_addr;
	logic [15:0] lfsr = 16'd75;
	logic hold, inval_ok;
	// burst accepted and its last beat not yet seen
	logic in_burst;
	ifu_pkg::fetch_out_t held;
	int xfer_cnt = 0;

	ifu_top dut (.clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.fetch(fetch), .redirect(redirect), .inval(inval), .ar_valid(ar_valid),
		.ar_ready(ar_ready), .ar(ar), .r_valid(r_valid), .r_ready(r_ready), .r(r));

	tb_mem_model u_mem (.clk(clk), .rst(rst), .ar_ok(ar_ok), .r_ok(r_ok), .ar_valid(ar_valid),
		.ar_ready(ar_ready), .ar(ar), .r_valid(r_valid), .r_ready(r_ready), .r(r));

	always #5 clk = !clk;

	// ************************************************************************
	// helpers
	// ************************************************************************

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], b};
			v = {v[30:0], b};
		end
		return v;
	endfunction

	// image word
	// one in four is a jal or branch with a small offset
	function automatic logic [31:0] image_word();
		logic [5:0] s;
		logic [20:0] oj;
		logic [12:0] ob;
		if (rand_bits(2) != 0) begin
			return rand_bits(32);
		end
		s = 6'(rand_bits(6));
		oj = {{13{s[5]}}, s, 2'b00};
		ob = {{5{s[5]}}, s, 2'b00};
		if (rand_bits(1) == 1) begin
			return {oj[20], oj[10:1], oj[11], oj[19:12], 5'd1, 7'b1101111};
		end
		return {ob[12], ob[10:5], 5'd2, 5'd1, 3'b000, ob[4:1], ob[11], 7'b1100011};
	endfunction

	// static prediction from the isa encodings
	function automatic logic taken_for(input logic [31:0] w);
		return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100011 && w[31]);
	endfunction

	function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
		if (w[6:0] == 7'b1101111) begin
			return pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end else if (w[6:0] == 7'b1100011 && w[31]) begin
			return pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		return pc + 32'd4;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial begin
		rst = 1'b1;
		fetch_ready = 1'b0;
		ar_ok = 1'b0;
		r_ok = 1'b0;
		redirect = '0;
		inval = '0;
		exp_pc = `IFU_RESET_PC;
		resident = '0;
		hold = 1'b0;
		inval_ok = 1'b0;
		in_burst = 1'b0;
		for (int i = 0; i < 256; i++) begin
			model_mem[i] = image_word();
			u_mem.mem[i] = model_mem[i];
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		wait (xfer_cnt >= N_FETCH);
		@(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

	always @(posedge clk) begin
		if (!rst) begin
			fetch_ready <= (rand_bits(2) != 0);
			ar_ok <= rand_bits(1) == 1;
			r_ok <= (rand_bits(2) != 0);
			redirect <= '0;
			inval <= '0;
			// redirects start once the boot fetch is through
			if (xfer_cnt > 0 && rand_bits(6) == 0) begin
				redirect <= '{valid: 1'b1,
					target: `IFU_RESET_PC | {22'd0, 8'(rand_bits(8)), 2'b00}};
			end
			// rewrite the resident line of the set at the expected pc
			if (inval_ok && rand_bits(5) == 0) begin
				if (resident[exp_pc[OFF_W +: IDX_W]]) begin
					rw_addr = {res_tag[exp_pc[OFF_W +: IDX_W]], exp_pc[OFF_W +: IDX_W],
						{OFF_W{1'b0}}};
				end else begin
					rw_addr = {exp_pc[31:OFF_W], {OFF_W{1'b0}}};
				end
				inval <= '{valid: 1'b1, addr: rw_addr};
			end
		end
	end

	// ************************************************************************
	// monitor and reference model sampled mid cycle
	// ************************************************************************

	always @(negedge clk) begin
		if (!rst) begin
			// held offer must not change
			if (hold && fetch_valid) begin
				check("fetch.pc", fetch.pc, held.pc);
				check("fetch.inst", fetch.inst, held.inst);
				check("fetch.pred_taken", 32'(fetch.pred_taken), 32'(held.pred_taken));
			end
			if (fetch_valid && fetch_ready) begin
				if (xfer_cnt == 0) begin
					check("first fetch.pc", fetch.pc, `IFU_RESET_PC);
				end
				check("fetch.pc", fetch.pc, exp_pc);
				check("fetch.inst", fetch.inst, model_mem[exp_pc[9:2]]);
				check("fetch.pred_taken", 32'(fetch.pred_taken),
					32'(taken_for(model_mem[exp_pc[9:2]])));
				exp_pc = next_pc(exp_pc, model_mem[exp_pc[9:2]]);
				xfer_cnt++;
			end
			if (redirect.valid) begin
				exp_pc = redirect.target;
			end
			hold = fetch_valid && !fetch_ready;
			held = fetch;
			// data ready only inside an accepted burst
			check("r_ready", 32'(r_ready), 32'(in_burst));
			// refill requests only for lines not resident
			if (ar_valid && ar_ready) begin
				check("ar.addr offset", 32'(ar.addr[OFF_W-1:0]), 32'd0);
				check("ar.len", 32'(ar.len), 32'(`IC_LINE_WORDS - 1));
				check("ar line resident", 32'(resident[ar.addr[OFF_W +: IDX_W]]
					&& res_tag[ar.addr[OFF_W +: IDX_W]] == ar.addr[31 -: TAG_W]), 32'd0);
				fill_addr = ar.addr;
				in_burst = 1'b1;
			end
			if (r_valid && r_ready && r.last) begin
				resident[fill_addr[OFF_W +: IDX_W]] = 1'b1;
				res_tag[fill_addr[OFF_W +: IDX_W]] = fill_addr[31 -: TAG_W];
				in_burst = 1'b0;
			end
			// invalidate applies after the fill and the memory then takes the new line
			if (inval.valid) begin
				if (res_tag[inval.addr[OFF_W +: IDX_W]] == inval.addr[31 -: TAG_W]) begin
					resident[inval.addr[OFF_W +: IDX_W]] = 1'b0;
				end
				for (int k = 0; k < `IC_LINE_WORDS; k++) begin
					model_mem[inval.addr[9:2] + 8'(k)] = image_word();
					u_mem.mem[inval.addr[9:2] + 8'(k)] = model_mem[inval.addr[9:2] + 8'(k)];
				end
			end
			// rewrites only while no burst is under way so a line is never torn
			inval_ok = !u_mem.busy && !ar_valid && !inval.valid;
		end
	end

	// watchdog
	initial begin
		#((N_FETCH * CYC_PER_FETCH + 8) * 10);
		$display("timeout: the fetch unit stopped delivering instructions");
		$display("STATUS: FAIL");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/ifu_pkg.sv
hdl/mem_pkg.sv
hdl/icache_tags.sv
hdl/icache_data.sv
hdl/fetch_ctrl.sv
hdl/ifu_top.sv
test/tb_mem_model.sv
test/tb_ifu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_ifu
RTL_TOP   ?= ifu_top
FLIST     ?= flist.f
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
